//--- sbox_unit.f
+incdir+bench
logic/gf64_pkg.sv
logic/gf64_mul.sv
logic/sbox_decode.sv
logic/gf64_pow52.sv
logic/sbox_execute.sv
logic/sbox_result.sv
logic/sbox_unit.sv
bench/sbox_unit_tb.sv

//--- run.sh
#!/bin/sh
# Compile the sbox_unit testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
  --top-module sbox_unit_tb \
  -f sbox_unit.f \
  -o Vsbox_unit_tb

./obj_dir/Vsbox_unit_tb | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

//--- bench/sbox_model.svh
`ifndef SBOX_MODEL_SVH
`define SBOX_MODEL_SVH

// ############################################################################
// Reference model of the tower field and the S-box
// ############################################################################

function automatic logic [1:0] gf4_product(logic [1:0] x, logic [1:0] y);
  logic [1:0] r;
  r[0] = (x[0] & y[0]) ^ (x[1] & y[1]);
  r[1] = (x[0] & y[1]) ^ (x[1] & y[0]) ^ (x[1] & y[1]);  // w^2 = w + 1
  return r;
endfunction

function automatic logic [5:0] gf64_product(logic [5:0] x, logic [5:0] y);
  logic [1:0] c [5];
  logic [5:0] r;
  for (int k = 0; k < 5; k++) begin
    c[k] = 2'b00;
  end
  for (int i = 0; i < 3; i++) begin
    for (int j = 0; j < 3; j++) begin
      c[i+j] = c[i+j] ^ gf4_product(x[2*i +: 2], y[2*j +: 2]);
    end
  end
  // Reduce with t^3 = w
  r[1:0] = c[0] ^ gf4_product(c[3], 2'b10);
  r[3:2] = c[1] ^ gf4_product(c[4], 2'b10);
  r[5:4] = c[2];
  return r;
endfunction

function automatic logic [5:0] pow_52(logic [5:0] x);
  logic [5:0] e;
  logic [5:0] r;
  e = 6'd52;
  r = 6'b000001;
  for (int i = 5; i >= 0; i--) begin
    r = gf64_product(r, r);
    if (e[i]) begin
      r = gf64_product(r, x);
    end
  end
  return r;
endfunction

function automatic logic [5:0] in_layer(logic [5:0] x);
  return {x[1] ^ x[2] ^ x[5], x[2] ^ x[4], x[3] ^ x[4],
          x[1] ^ x[4], x[1] ^ x[2] ^ x[4], x[0] ^ x[3] ^ x[4]};
endfunction

function automatic logic [5:0] out_layer(logic [5:0] x);
  return {x[2] ^ x[4], ^x, x[0] ^ x[2] ^ x[3] ^ x[5],
          x[2] ^ x[3], x[1] ^ x[5], x[2] ^ x[5]};
endfunction

function automatic logic [5:0] sbox_lookup(logic [5:0] x);
  return out_layer(pow_52(in_layer(x))) ^ {6{x[2] ^ x[4]}};
endfunction

`endif

//--- bench/sbox_unit_tb.sv
`timescale 1ns/1ps
module sbox_unit_tb
  import gf64_pkg::*;
();

  `include "sbox_model.svh"

  localparam int N_CMDS          = 64 + 200 + 64 + 64 + 1 + 3;
  localparam int WATCHDOG_CYCLES = N_CMDS * 10 + 200;  // A power command spans about ten cycles
  localparam int MAX_WAIT        = 20;

  logic clk;
  logic arst_n;
  logic start;
  cmd_t cmd;
  logic res_valid;
  res_t res;
  logic busy;

  int n_tests;
  int n_checks;
  int n_errors;

  sbox_unit u_sbox_unit (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .cmd       (cmd),
    .res_valid (res_valid),
    .res       (res),
    .busy      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  // ##########################################################################
  // Helpers
  // ##########################################################################

  task automatic compare_hex(input string name, input logic [5:0] seen, input logic [5:0] exp);
    n_checks++;
    if (seen !== exp) begin
      $display("ERR %s seen 0x%0h expected 0x%0h", name, seen, exp);
      n_errors++;
    end
  endtask

  task automatic check_latency(input int lat, input int exp);
    n_checks++;
    if (lat != exp) begin
      $display("res_valid came %0d cycles after the start strobe instead of %0d", lat, exp);
      n_errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    n_tests++;
    if (n_errors == err_before) begin
      $display("%-12s ok", name);
    end else begin
      $display("%-12s failed with %0d errors", name, n_errors - err_before);
    end
  endtask

  // Strobe one command, then wait for its result; lat counts edges after the sampling edge
  task automatic issue_cmd(input logic [1:0] op, input gf64_t a, input gf64_t b,
                           output int lat, output res_t got);
    @(posedge clk);
    #0.5;
    cmd   = cmd_t'({op, a, b});
    start = 1'b1;
    @(posedge clk);
    #0.5;
    start = 1'b0;
    lat   = 0;
    got   = '0;
    @(negedge clk);
    while (!res_valid && lat < MAX_WAIT) begin
      @(negedge clk);
      lat++;
    end
    if (!res_valid) begin
      $display("No res_valid within %0d cycles for opcode %0d", MAX_WAIT, op);
      n_errors++;
    end else begin
      got = res;
      compare_hex("busy", {5'b0, busy}, 6'h0);  // Busy drops in the result cycle
    end
  endtask

  // ##########################################################################
  // Directed tests
  // ##########################################################################

  task automatic idle_after_reset();
    int err0;
    err0 = n_errors;
    repeat (10) begin
      @(negedge clk);
      compare_hex("busy", {5'b0, busy}, 6'h0);
      compare_hex("res_valid", {5'b0, res_valid}, 6'h0);
      compare_hex("res.data", res.data, 6'h0);
      compare_hex("res.err", {5'b0, res.err}, 6'h0);
    end
    report_test("reset_idle", err0);
  endtask

  task automatic mul_sweep();
    int    err0;
    int    lat;
    res_t  got;
    gf64_t a;
    gf64_t b;
    err0 = n_errors;
    for (int x = 0; x < 64; x++) begin
      issue_cmd(OP_MUL, gf64_t'(x), 6'h01, lat, got);  // One is the neutral element
      check_latency(lat, 2);
      compare_hex("res.data", got.data, gf64_t'(x));
      compare_hex("res.err", {5'b0, got.err}, 6'h0);
    end
    for (int n = 0; n < 200; n++) begin
      a = 6'($urandom());
      b = 6'($urandom());
      issue_cmd(OP_MUL, a, b, lat, got);
      check_latency(lat, 2);
      compare_hex("res.data", got.data, gf64_product(a, b));
    end
    report_test("mul", err0);
  endtask

  task automatic pow_sweep();
    int   err0;
    int   lat;
    res_t got;
    err0 = n_errors;
    for (int x = 0; x < 64; x++) begin
      issue_cmd(OP_POW, gf64_t'(x), 6'h00, lat, got);
      check_latency(lat, 8);
      compare_hex("res.data", got.data, pow_52(gf64_t'(x)));
      compare_hex("res.err", {5'b0, got.err}, 6'h0);
    end
    report_test("pow52", err0);
  endtask

  task automatic sbox_sweep();
    int   err0;
    int   lat;
    res_t got;
    err0 = n_errors;
    for (int x = 0; x < 64; x++) begin
      issue_cmd(OP_SBOX, gf64_t'(x), 6'h00, lat, got);
      check_latency(lat, 8);
      compare_hex("res.data", got.data, sbox_lookup(gf64_t'(x)));
    end
    report_test("sbox", err0);
  endtask

  task automatic illegal_opcode();
    int   err0;
    int   lat;
    res_t got;
    err0 = n_errors;
    issue_cmd(2'd3, 6'h2a, 6'h15, lat, got);
    check_latency(lat, 2);
    compare_hex("res.err", {5'b0, got.err}, 6'h1);
    compare_hex("res.data", got.data, 6'h0);
    report_test("illegal_op", err0);
  endtask

  task automatic busy_drop();
    int    err0;
    int    pulses;
    gf64_t a;
    gf64_t first;
    err0   = n_errors;
    pulses = 0;
    a      = 6'h2b;
    first  = '0;
    @(posedge clk);
    #0.5;
    cmd   = cmd_t'({OP_POW, a, 6'h00});
    start = 1'b1;
    @(posedge clk);
    #0.5;
    cmd = cmd_t'({OP_MUL, 6'h15, 6'h07});  // Strobe held into the busy cycle
    n_checks++;
    if (!busy) begin
      $display("busy is low right after an accepted start strobe");
      n_errors++;
    end
    @(posedge clk);
    #0.5;
    start = 1'b0;
    repeat (2) @(posedge clk);
    #0.5;
    cmd   = cmd_t'({2'd3, 6'h00, 6'h00});
    start = 1'b1;  // Another strobe in the middle of the power run
    @(posedge clk);
    #0.5;
    start = 1'b0;
    repeat (MAX_WAIT) begin
      @(negedge clk);
      if (res_valid) begin
        pulses++;
        if (pulses == 1) begin
          first = res.data;
        end
      end
    end
    n_checks++;
    if (pulses != 1) begin
      $display("Expected one res_valid pulse while busy, saw %0d", pulses);
      n_errors++;
    end
    compare_hex("res.data", first, pow_52(a));
    report_test("busy_drop", err0);
  endtask

  // ##########################################################################
  // Main sequence
  // ##########################################################################

  initial begin
    arst_n   = 1'b0;
    start    = 1'b0;
    cmd      = '0;
    n_tests  = 0;
    n_checks = 0;
    n_errors = 0;
    void'($urandom(32'h5f81_1af0));
    repeat (8) @(posedge clk);
    #0.5;
    arst_n = 1'b1;

    idle_after_reset();
    mul_sweep();
    pow_sweep();
    sbox_sweep();
    illegal_opcode();
    busy_drop();

    repeat (2) @(posedge clk);
    $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- logic/sbox_unit.sv
`timescale 1ns/1ps
module sbox_unit
  import gf64_pkg::*;
(
  input  logic clk,
  input  logic arst_n,
  input  logic start,
  input  cmd_t cmd,
  output logic res_valid,
  output res_t res,
  output logic busy
);

  logic dec_valid;
  dec_t dec;
  logic ex_valid;
  res_t ex_res;

  sbox_decode u_decode (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .cmd       (cmd),
    .busy      (busy),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  sbox_execute u_execute (
    .clk       (clk),
    .arst_n    (arst_n),
    .dec_valid (dec_valid),
    .dec       (dec),
    .ex_valid  (ex_valid),
    .ex_res    (ex_res)
  );

  sbox_result u_result (
    .clk         (clk),
    .arst_n      (arst_n),
    .start_taken (dec_valid),
    .ex_valid    (ex_valid),
    .ex_res      (ex_res),
    .res_valid   (res_valid),
    .res         (res),
    .busy        (busy)
  );

endmodule

//--- logic/sbox_result.sv
`timescale 1ns/1ps
module sbox_result
  import gf64_pkg::*;
(
  input  logic clk,
  input  logic arst_n,
  input  logic start_taken,
  input  logic ex_valid,
  input  res_t ex_res,
  output logic res_valid,
  output res_t res,
  output logic busy
);

  logic busy_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q    <= 1'b0;
      res_valid <= 1'b0;
      res       <= '0;
    end else begin
      res_valid <= ex_valid;
      if (ex_valid) begin
        res    <= ex_res;
        busy_q <= 1'b0;  // Drops together with the valid pulse
      end else if (start_taken) begin
        busy_q <= 1'b1;
      end
    end
  end

  // Covers the cycle right after the accepted strobe, before busy_q is set
  assign busy = busy_q || start_taken;

endmodule

//--- logic/sbox_execute.sv
`timescale 1ns/1ps
module sbox_execute
  import gf64_pkg::*;
(
  input  logic clk,
  input  logic arst_n,
  input  logic dec_valid,
  input  dec_t dec,
  output logic ex_valid,
  output res_t ex_res
);

  gf64_t    prod;
  gf64_t    pow_base;
  gf64_t    pow_res;
  logic     pow_go;
  logic     pow_done;
  logic     short_cmd;
  logic     fix_bit;
  sbox_op_e op_q;
  gf64_t    a_q;

  gf64_mul u_mul (
    .a (dec.a),
    .b (dec.b),
    .p (prod)
  );

  // Multiply and illegal commands finish in one cycle
  assign short_cmd = dec.illegal || (dec.op == OP_MUL);
  assign pow_go    = dec_valid && !short_cmd;
  assign pow_base  = (dec.op == OP_SBOX) ? map_in(dec.a) : dec.a;

  gf64_pow52 u_pow (
    .clk    (clk),
    .arst_n (arst_n),
    .go     (pow_go),
    .base   (pow_base),
    .done   (pow_done),
    .result (pow_res)
  );

  always_ff @(posedge clk) begin
    if (pow_go) begin
      op_q <= dec.op;
      a_q  <= dec.a;
    end
  end

  assign fix_bit = a_q[2] ^ a_q[4];  // Correction term of the S-box

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= (dec_valid && short_cmd) || pow_done;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid && dec.illegal) begin
      ex_res <= '{data: '0, err: 1'b1};
    end else if (dec_valid && dec.op == OP_MUL) begin
      ex_res <= '{data: prod, err: 1'b0};
    end else if (pow_done) begin
      if (op_q == OP_SBOX) begin
        ex_res <= '{data: map_out(pow_res) ^ {6{fix_bit}}, err: 1'b0};
      end else begin
        ex_res <= '{data: pow_res, err: 1'b0};
      end
    end
  end

endmodule

//--- logic/gf64_pow52.sv
`timescale 1ns/1ps
module gf64_pow52
  import gf64_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  go,
  input  gf64_t base,
  output logic  done,
  output gf64_t result
);

  pow_state_e state;
  logic [2:0] bit_idx;
  gf64_t      acc;
  gf64_t      base_q;
  gf64_t      sq_in;
  gf64_t      mul_base;
  gf64_t      sq;
  gf64_t      sq_x_base;
  gf64_t      step;
  logic       bit_set;

  // ##########################################################################
  // One square-and-multiply step per cycle
  // ##########################################################################

  // The go cycle already takes the MSB, with the accumulator seen as 1
  assign sq_in    = (state == POW_IDLE) ? GF64_ONE : acc;
  assign mul_base = (state == POW_IDLE) ? base : base_q;
  assign bit_set  = (state == POW_IDLE) ? POW_EXP[POW_TOP] : POW_EXP[bit_idx];

  gf64_mul u_square (
    .a (sq_in),
    .b (sq_in),
    .p (sq)
  );

  gf64_mul u_times_base (
    .a (sq),
    .b (mul_base),
    .p (sq_x_base)
  );

  assign step = bit_set ? sq_x_base : sq;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= POW_IDLE;
      bit_idx <= '0;
    end else begin
      case (state)
        POW_IDLE: begin
          if (go) begin
            state   <= POW_RUN;
            bit_idx <= POW_TOP - 3'd1;
          end
        end
        POW_RUN: begin
          if (bit_idx == 3'd0) begin
            state <= POW_DONE;  // LSB consumed in this step
          end
          bit_idx <= bit_idx - 3'd1;
        end
        POW_DONE: state <= POW_IDLE;
        default:  state <= POW_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == POW_IDLE && go) begin
      base_q <= base;
      acc    <= step;
    end else if (state == POW_RUN) begin
      acc <= step;
    end
  end

  assign done   = (state == POW_DONE);
  assign result = acc;

endmodule

//--- logic/sbox_decode.sv
`timescale 1ns/1ps
module sbox_decode
  import gf64_pkg::*;
(
  input  logic clk,
  input  logic arst_n,
  input  logic start,
  input  cmd_t cmd,
  input  logic busy,
  output logic dec_valid,
  output dec_t dec
);

  logic accept;
  logic illegal;

  assign accept = start && !busy;  // Strobes during a command are dropped

  always_comb begin
    case (cmd.op)
      OP_SBOX, OP_MUL, OP_POW: illegal = 1'b0;
      default:                 illegal = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dec <= '{op: cmd.op, a: cmd.a, b: cmd.b, illegal: illegal};
    end
  end

endmodule

//--- logic/gf64_mul.sv
`timescale 1ns/1ps
module gf64_mul
  import gf64_pkg::*;
(
  input  gf64_t a,
  input  gf64_t b,
  output gf64_t p
);

  // GF(4) product with w^2 = w + 1
  function automatic logic [1:0] gf4_mul(logic [1:0] x, logic [1:0] y);
    logic hi;
    hi = x[1] & y[1];
    return {(x[0] & y[1]) ^ (x[1] & y[0]) ^ hi, (x[0] & y[0]) ^ hi};
  endfunction

  function automatic logic [1:0] gf4_mul_w(logic [1:0] x);
    return {x[0] ^ x[1], x[1]};
  endfunction

  logic [1:0] c [5];  // Unreduced coefficients of t^0 .. t^4

  always_comb begin
    for (int k = 0; k < 5; k++) begin
      c[k] = 2'b00;
    end
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        c[i+j] = c[i+j] ^ gf4_mul(a[2*i +: 2], b[2*j +: 2]);
      end
    end
  end

  // t^3 = w folds into t^0 and t^4 = w*t folds into t^1
  assign p = {c[2], c[1] ^ gf4_mul_w(c[4]), c[0] ^ gf4_mul_w(c[3])};

endmodule

//--- logic/gf64_pkg.sv
package gf64_pkg;

  // ##########################################################################
  // Field element and command types
  // ##########################################################################

  typedef logic [5:0] gf64_t;  // Digits t^2 in 5:4, t^1 in 3:2, t^0 in 1:0

  typedef enum logic [1:0] {
    OP_SBOX = 2'd0,
    OP_MUL  = 2'd1,
    OP_POW  = 2'd2
  } sbox_op_e;

  typedef enum logic [1:0] {
    POW_IDLE,
    POW_RUN,
    POW_DONE
  } pow_state_e;

  typedef struct packed {
    sbox_op_e op;
    gf64_t    a;
    gf64_t    b;
  } cmd_t;

  typedef struct packed {
    sbox_op_e op;
    gf64_t    a;
    gf64_t    b;
    logic     illegal;
  } dec_t;

  typedef struct packed {
    gf64_t data;
    logic  err;
  } res_t;

  localparam gf64_t      POW_EXP  = 6'b110100;  // 52
  localparam logic [2:0] POW_TOP  = 3'd5;       // MSB position of POW_EXP
  localparam gf64_t      GF64_ONE = 6'b000001;

  // ##########################################################################
  // Linear layers around the power
  // ##########################################################################

  function automatic gf64_t map_in(gf64_t x);
    gf64_t y;
    y[0] = x[0] ^ x[3] ^ x[4];
    y[1] = x[1] ^ x[2] ^ x[4];
    y[2] = x[1] ^ x[4];
    y[3] = x[3] ^ x[4];
    y[4] = x[2] ^ x[4];
    y[5] = x[1] ^ x[2] ^ x[5];
    return y;
  endfunction

  function automatic gf64_t map_out(gf64_t x);
    gf64_t y;
    y[0] = x[2] ^ x[5];
    y[1] = x[1] ^ x[5];
    y[2] = x[2] ^ x[3];
    y[3] = x[0] ^ x[2] ^ x[3] ^ x[5];
    y[4] = ^x;  // Parity of all six bits
    y[5] = x[2] ^ x[4];
    return y;
  endfunction

endpackage
